// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_sram_spu
RTL_TOP   := sram_spu_top
FILELIST  := sram_spu.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/sram_spu_stim.txt
# W adr sel data : bus write, all fields hex
# R adr expected : read and compare, P : poll until done, S : expect busy
R 001 0
R 004 0
R 006 0
W 001 ff fc
W 004 ff 8
R 001 fc
R 004 8
# byte masked writes into A, B and D
W 400 ff 1111111111111111
W 400 0f aaaaaaaaaaaaaaaa
R 400 11111111aaaaaaaa
W 800 ff 2222222222222222
W 800 c3 bbbbbbbbbbbbbbbb
R 800 bbbb22222222bbbb
W c05 ff 3333333333333333
W c05 30 cccccccccccccccc
R c05 3333cccc33333333
# add with length 8, source and destination ranges wrap past ff
W 4fc ff 1
W 4fd ff 2
W 4fe ff 3
W 4ff ff 4
W 401 ff ffffffffffffffff
W 402 ff 7
W 403 ff 8
W 8fe ff 10
W 8ff ff 20
W 801 ff 30
W 802 ff 40
W 803 ff 50
W 804 ff 60
W 805 ff 70
W 002 ff fe
W 003 ff fd
W 005 ff 0
W 000 ff 1
P
R cfd 11
R cfe 22
R cff bbbb22222222bbbe
R c00 34
R c01 11111111aaaaaaea
R c02 4f
R c03 67
R c04 78
R c05 3333cccc33333333
# length 1 runs from A[00] and B[00] into D[10]
W 001 ff 0
W 002 ff 0
W 003 ff 10
W 004 ff 1
W 005 ff 1
W 000 ff 1
P
R c10 5555eeef8887eeef
W 005 ff 2
W 000 ff 1
P
R c10 111100002222aaaa
W 005 ff 3
W 000 ff 1
P
R c10 aaaa333388881111
W 005 ff 4
W 000 ff 1
P
R c10 bbbb22222222bbbb
# code 6 is unused and passes A through
W 005 ff 6
W 000 ff 1
P
R c10 11111111aaaaaaaa
R 005 6
# empty run leaves D alone
W 004 ff 0
W 003 ff 0
W 000 ff 1
P
R c00 34
# length 256 copy of A to D[80], the second start while busy is dropped
W 004 ff 100
W 003 ff 80
W 000 ff 1
S
W 003 ff 20
W 005 ff 0
W 000 ff 1
S
P
R c80 11111111aaaaaaaa
R c81 ffffffffffffffff
R c7f 4
R 003 20

// File: sim/tb_sram_spu.sv
`timescale 1ns/1ps

module tb_sram_spu;
    import sram_spu_pkg::*;

    localparam int ACK_TIMEOUT  = 20;
    localparam int POLL_TIMEOUT = 2000;
    localparam logic [WB_ADR_WIDTH-1:0] STATUS_ADR = {REGION_REGS, 2'b00, REG_STATUS};

    logic                    clk300;
    logic                    rst_i;
    logic [WB_ADR_WIDTH-1:0] s_wb_adr_i;
    logic [WB_DAT_WIDTH-1:0] s_wb_dat_i;
    logic [WB_SEL_WIDTH-1:0] s_wb_sel_i;
    logic                    s_wb_we_i;
    logic                    s_wb_stb_i;
    logic [WB_DAT_WIDTH-1:0] s_wb_dat_o;
    logic                    s_wb_ack_o;

    int cycle = 0;
    int value_errors = 0;
    int handshake_errors = 0;
    int stim_errors = 0;

    sram_spu_top dut (
        .clk300     (clk300),
        .rst_i      (rst_i),
        .s_wb_adr_i (s_wb_adr_i),
        .s_wb_dat_i (s_wb_dat_i),
        .s_wb_sel_i (s_wb_sel_i),
        .s_wb_we_i  (s_wb_we_i),
        .s_wb_stb_i (s_wb_stb_i),
        .s_wb_dat_o (s_wb_dat_o),
        .s_wb_ack_o (s_wb_ack_o)
    );

    initial begin
        clk300 = 1'b0;
        forever begin
            #5 clk300 = ~clk300;
        end
    end

    // cycle count for the status poll limit
    always @(posedge clk300) begin
        cycle <= cycle + 1;
    end

    // one wishbone access, called 1 ns after a rising edge
    task automatic bus_access(input logic [WB_ADR_WIDTH-1:0] adr,
                              input logic [WB_SEL_WIDTH-1:0] sel,
                              input logic                    we,
                              input logic [WB_DAT_WIDTH-1:0] dat,
                              output logic [WB_DAT_WIDTH-1:0] rdata,
                              output logic                    ok);
        int waited;
        waited     = 0;
        rdata      = '0;
        ok         = 1'b0;
        s_wb_adr_i = adr;
        s_wb_sel_i = sel;
        s_wb_we_i  = we;
        s_wb_dat_i = dat;
        s_wb_stb_i = 1'b1;
        do begin
            @(posedge clk300);
            #1;
            waited++;
        end while (!s_wb_ack_o && waited < ACK_TIMEOUT);
        if (!s_wb_ack_o) begin
            $display("timeout: no ack within %0d cycles for address %h at time %0t",
                     ACK_TIMEOUT, adr, $time);
            handshake_errors++;
        end else begin
            ok    = 1'b1;
            rdata = s_wb_dat_o;
            // stb held one more cycle, ack must stay low there
            @(posedge clk300);
            #1;
            if (s_wb_ack_o) begin
                $display("second ack seen for one access to address %h at time %0t",
                         adr, $time);
                handshake_errors++;
            end
        end
        s_wb_stb_i = 1'b0;
        s_wb_we_i  = 1'b0;
    endtask

    task automatic read_expect(input logic [WB_ADR_WIDTH-1:0] adr,
                               input logic [WB_DAT_WIDTH-1:0] expected);
        logic [WB_DAT_WIDTH-1:0] rdata;
        logic                    ok;
        bus_access(adr, '1, 1'b0, '0, rdata, ok);
        if (ok && rdata !== expected) begin
            $display("FAIL %0t: address %h expected %h got %h", $time, adr, expected, rdata);
            value_errors++;
        end
    endtask

    // status bit 0 is busy
    task automatic expect_busy();
        logic [WB_DAT_WIDTH-1:0] status;
        logic                    ok;
        bus_access(STATUS_ADR, '1, 1'b0, '0, status, ok);
        if (ok && status[0] !== 1'b1) begin
            $display("FAIL %0t: address %h expected busy set got %h", $time, STATUS_ADR, status);
            value_errors++;
        end
    endtask

    // status bit 1 is the sticky done
    task automatic poll_done();
        logic [WB_DAT_WIDTH-1:0] status;
        logic                    ok;
        int                      start_cycle;
        start_cycle = cycle;
        status      = '0;
        while (status[1] !== 1'b1 && cycle - start_cycle < POLL_TIMEOUT) begin
            bus_access(STATUS_ADR, '1, 1'b0, '0, status, ok);
        end
        if (status[1] !== 1'b1) begin
            $display("timeout: done not set within %0d cycles at time %0t",
                     POLL_TIMEOUT, $time);
            handshake_errors++;
        end
    endtask

    initial begin
        int                      fd;
        int                      code;
        logic [7:0]              cmd;
        logic [8*128-1:0]        line;
        logic [WB_ADR_WIDTH-1:0] adr;
        logic [WB_SEL_WIDTH-1:0] sel;
        logic [WB_DAT_WIDTH-1:0] data;
        logic [WB_DAT_WIDTH-1:0] rdata;
        logic                    ok;

        rst_i      = 1'b1;
        s_wb_adr_i = '0;
        s_wb_dat_i = '0;
        s_wb_sel_i = '0;
        s_wb_we_i  = 1'b0;
        s_wb_stb_i = 1'b0;
        repeat (4) @(posedge clk300);
        #1;
        rst_i = 1'b0;
        if (s_wb_ack_o !== 1'b0) begin
            $display("FAIL %0t: ack expected low after reset got %b", $time, s_wb_ack_o);
            value_errors++;
        end

        fd = $fopen("sim/sram_spu_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file sim/sram_spu_stim.txt");
            stim_errors++;
        end else begin
            code = $fscanf(fd, "%s", cmd);
            while (code == 1) begin
                if (cmd == "#") begin
                    code = $fgets(line, fd);
                end else if (cmd == "W") begin
                    code = $fscanf(fd, "%h %h %h", adr, sel, data);
                    if (code != 3) begin
                        $display("malformed write line in the stimulus file");
                        stim_errors++;
                    end else begin
                        bus_access(adr, sel, 1'b1, data, rdata, ok);
                    end
                end else if (cmd == "R") begin
                    code = $fscanf(fd, "%h %h", adr, data);
                    if (code != 2) begin
                        $display("malformed read line in the stimulus file");
                        stim_errors++;
                    end else begin
                        read_expect(adr, data);
                    end
                end else if (cmd == "P") begin
                    poll_done();
                end else if (cmd == "S") begin
                    expect_busy();
                end else begin
                    $display("unknown command %0s in the stimulus file", cmd);
                    stim_errors++;
                end
                code = $fscanf(fd, "%s", cmd);
            end
            $fclose(fd);
        end

        $display("errors: %0d value, %0d handshake or timeout, %0d stimulus file",
                 value_errors, handshake_errors, stim_errors);
        if (value_errors == 0 && handshake_errors == 0 && stim_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: source/sram_spu_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_spu_bank (
    input  var logic                                   clk300,
    input  var sram_spu_pkg::bank_wb_t                 bus_req_i,
    input  var logic [sram_spu_pkg::BANK_AW-1:0]       eng_idx_i,
    input  var logic                                   eng_we_i,
    input  var logic [sram_spu_pkg::WB_DAT_WIDTH-1:0]  eng_wdata_i,
    output var logic [sram_spu_pkg::WB_DAT_WIDTH-1:0]  bus_rdata_o,
    output var logic [sram_spu_pkg::WB_DAT_WIDTH-1:0]  eng_rdata_o
);
    import sram_spu_pkg::*;

    logic [WB_DAT_WIDTH-1:0] mem [2**BANK_AW];

    always_ff @(posedge clk300) begin
        // bus port, byte masked writes
        if (bus_req_i.en) begin
            if (bus_req_i.we) begin
                for (int b = 0; b < WB_SEL_WIDTH; b++) begin
                    if (bus_req_i.sel[b]) begin
                        mem[bus_req_i.idx][b*8 +: 8] <= bus_req_i.dat[b*8 +: 8];
                    end
                end
            end
            bus_rdata_o <= mem[bus_req_i.idx];
        end
        // engine port, full word writes and a read every cycle
        if (eng_we_i) begin
            mem[eng_idx_i] <= eng_wdata_i;
        end
        eng_rdata_o <= mem[eng_idx_i];
    end

endmodule

`default_nettype wire

// File: source/sram_spu_combiner.sv
`timescale 1ns/1ps
`default_nettype none

module sram_spu_combiner (
    input  var logic                     clk300,
    input  var logic                     rst_i,
    input  var sram_spu_pkg::rd_beat_t   beat_a_i,
    input  var sram_spu_pkg::rd_beat_t   beat_b_i,
    input  var sram_spu_pkg::spu_cfg_t   cfg_i,
    input  var logic                     start_i,
    output var sram_spu_pkg::wr_req_t    wr_o,
    output var logic                     done_o
);
    import sram_spu_pkg::*;

    logic                    wr_en_q;
    logic [BANK_AW-1:0]      wr_idx_q;
    logic [WB_DAT_WIDTH-1:0] wr_data_q;
    logic [BANK_AW-1:0]      dst_q;
    logic                    done_q;
    logic [WB_DAT_WIDTH-1:0] a;
    logic [WB_DAT_WIDTH-1:0] b;
    logic [WB_DAT_WIDTH-1:0] result;

    assign a = beat_a_i.data;
    assign b = beat_b_i.data;

    always_comb begin
        case (cfg_i.op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_XOR:  result = a ^ b;
            // unsigned compare
            OP_MAX:  result = (a > b) ? a : b;
            OP_PASS: result = a;
            default: result = a;
        endcase
    end

    always_ff @(posedge clk300) begin
        if (rst_i) begin
            wr_en_q <= 1'b0;
            done_q  <= 1'b0;
            dst_q   <= '0;
        end else begin
            wr_en_q <= beat_a_i.valid;
            // empty run finishes right after start
            done_q  <= (beat_a_i.valid && beat_a_i.last) ||
                       (start_i && (cfg_i.len == '0));
            if (start_i) begin
                dst_q <= cfg_i.dst;
            end else if (beat_a_i.valid) begin
                dst_q <= dst_q + BANK_AW'(1);
            end
        end
    end

    always_ff @(posedge clk300) begin
        wr_idx_q  <= dst_q;
        wr_data_q <= result;
    end

    assign wr_o.en   = wr_en_q;
    assign wr_o.idx  = wr_idx_q;
    assign wr_o.data = wr_data_q;
    assign done_o    = done_q;

    // both readers are started together and must stay in lock step
    readers_aligned: assert property (@(posedge clk300) disable iff (rst_i)
        beat_a_i.valid == beat_b_i.valid);

endmodule

`default_nettype wire

// File: source/sram_spu_pkg.sv
package sram_spu_pkg;

    // bus geometry
    localparam int WB_ADR_WIDTH = 12;
    localparam int WB_DAT_WIDTH = 64;
    localparam int WB_SEL_WIDTH = 8;

    localparam int BANK_AW = 8;
    // length may be 0..256
    localparam int LEN_W   = 9;

    // register indexes within the register region
    localparam logic [BANK_AW-1:0] REG_CTRL   = 8'd0;
    localparam logic [BANK_AW-1:0] REG_SRC_A  = 8'd1;
    localparam logic [BANK_AW-1:0] REG_SRC_B  = 8'd2;
    localparam logic [BANK_AW-1:0] REG_DST    = 8'd3;
    localparam logic [BANK_AW-1:0] REG_LEN    = 8'd4;
    localparam logic [BANK_AW-1:0] REG_OP     = 8'd5;
    localparam logic [BANK_AW-1:0] REG_STATUS = 8'd6;

    // address bits 11:10
    localparam logic [1:0] REGION_REGS = 2'd0;
    localparam logic [1:0] REGION_A    = 2'd1;
    localparam logic [1:0] REGION_B    = 2'd2;
    localparam logic [1:0] REGION_D    = 2'd3;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_XOR  = 3'd3,
        OP_MAX  = 3'd4,
        OP_PASS = 3'd7
    } spu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RUN   = 2'd1,
        ST_DRAIN = 2'd2
    } run_state_e;

    typedef struct packed {
        logic [BANK_AW-1:0] src_a;
        logic [BANK_AW-1:0] src_b;
        logic [BANK_AW-1:0] dst;
        logic [LEN_W-1:0]   len;
        spu_op_e            op;
    } spu_cfg_t;

    // bus side request into one bank
    typedef struct packed {
        logic                    en;
        logic                    we;
        logic [BANK_AW-1:0]      idx;
        logic [WB_DAT_WIDTH-1:0] dat;
        logic [WB_SEL_WIDTH-1:0] sel;
    } bank_wb_t;

    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic [WB_DAT_WIDTH-1:0] data;
    } rd_beat_t;

    typedef struct packed {
        logic                    en;
        logic [BANK_AW-1:0]      idx;
        logic [WB_DAT_WIDTH-1:0] data;
    } wr_req_t;

endpackage

// File: source/sram_spu_reader.sv
`timescale 1ns/1ps
`default_nettype none

module sram_spu_reader (
    input  var logic                                   clk300,
    input  var logic                                   rst_i,
    input  var logic                                   start_i,
    input  var logic [sram_spu_pkg::BANK_AW-1:0]       offset_i,
    input  var logic [sram_spu_pkg::LEN_W-1:0]         len_i,
    input  var logic [sram_spu_pkg::WB_DAT_WIDTH-1:0]  rdata_i,
    output var logic [sram_spu_pkg::BANK_AW-1:0]       rd_idx_o,
    output var sram_spu_pkg::rd_beat_t                 beat_o
);
    import sram_spu_pkg::*;

    logic               active_q;
    logic [BANK_AW-1:0] idx_q;
    logic [LEN_W-1:0]   cnt_q;
    logic               valid_q;
    logic               last_q;

    // one read per active cycle
    assign rd_idx_o = idx_q;

    always_ff @(posedge clk300) begin
        if (rst_i) begin
            active_q <= 1'b0;
            idx_q    <= '0;
            cnt_q    <= '0;
            valid_q  <= 1'b0;
            last_q   <= 1'b0;
        end else begin
            // valid/last trail the read by the sram latency
            valid_q <= active_q;
            last_q  <= active_q && (cnt_q == LEN_W'(1));
            if (start_i) begin
                active_q <= (len_i != '0);
                idx_q    <= offset_i;
                cnt_q    <= len_i;
            end else if (active_q) begin
                // index wraps naturally at 256
                idx_q <= idx_q + BANK_AW'(1);
                cnt_q <= cnt_q - LEN_W'(1);
                if (cnt_q == LEN_W'(1)) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    assign beat_o.valid = valid_q;
    assign beat_o.last  = last_q;
    assign beat_o.data  = rdata_i;

    // a new stream never starts on top of a running one
    start_when_idle: assert property (@(posedge clk300) disable iff (rst_i)
        start_i |-> !active_q);

endmodule

`default_nettype wire

// File: source/sram_spu_top.sv
`timescale 1ns/1ps
`default_nettype none

module sram_spu_top (
    input  var logic                                   clk300,
    input  var logic                                   rst_i,
    input  var logic [sram_spu_pkg::WB_ADR_WIDTH-1:0]  s_wb_adr_i,
    input  var logic [sram_spu_pkg::WB_DAT_WIDTH-1:0]  s_wb_dat_i,
    input  var logic [sram_spu_pkg::WB_SEL_WIDTH-1:0]  s_wb_sel_i,
    input  var logic                                   s_wb_we_i,
    input  var logic                                   s_wb_stb_i,
    output var logic [sram_spu_pkg::WB_DAT_WIDTH-1:0]  s_wb_dat_o,
    output var logic                                   s_wb_ack_o
);
    import sram_spu_pkg::*;

    bank_wb_t [2:0]                bank_req;
    logic [2:0][WB_DAT_WIDTH-1:0]  bus_rdata;
    spu_cfg_t                      cfg;
    logic                          start;
    logic                          done;
    logic [BANK_AW-1:0]            rd_idx_a;
    logic [BANK_AW-1:0]            rd_idx_b;
    logic [WB_DAT_WIDTH-1:0]       eng_rdata_a;
    logic [WB_DAT_WIDTH-1:0]       eng_rdata_b;
    rd_beat_t                      beat_a;
    rd_beat_t                      beat_b;
    wr_req_t                       wr;

    sram_spu_wb_regs u_regs (
        .clk300       (clk300),
        .rst_i        (rst_i),
        .wb_adr_i     (s_wb_adr_i),
        .wb_dat_i     (s_wb_dat_i),
        .wb_sel_i     (s_wb_sel_i),
        .wb_we_i      (s_wb_we_i),
        .wb_stb_i     (s_wb_stb_i),
        .done_i       (done),
        .bank_rdata_i (bus_rdata),
        .wb_dat_o     (s_wb_dat_o),
        .wb_ack_o     (s_wb_ack_o),
        .bank_req_o   (bank_req),
        .cfg_o        (cfg),
        .start_o      (start)
    );

    // source banks only read on the engine side
    sram_spu_bank u_bank_a (
        .clk300      (clk300),
        .bus_req_i   (bank_req[0]),
        .eng_idx_i   (rd_idx_a),
        .eng_we_i    (1'b0),
        .eng_wdata_i ('0),
        .bus_rdata_o (bus_rdata[0]),
        .eng_rdata_o (eng_rdata_a)
    );

    sram_spu_bank u_bank_b (
        .clk300      (clk300),
        .bus_req_i   (bank_req[1]),
        .eng_idx_i   (rd_idx_b),
        .eng_we_i    (1'b0),
        .eng_wdata_i ('0),
        .bus_rdata_o (bus_rdata[1]),
        .eng_rdata_o (eng_rdata_b)
    );

    sram_spu_bank u_bank_d (
        .clk300      (clk300),
        .bus_req_i   (bank_req[2]),
        .eng_idx_i   (wr.idx),
        .eng_we_i    (wr.en),
        .eng_wdata_i (wr.data),
        .bus_rdata_o (bus_rdata[2]),
        .eng_rdata_o ()
    );

    sram_spu_reader u_rd_a (
        .clk300   (clk300),
        .rst_i    (rst_i),
        .start_i  (start),
        .offset_i (cfg.src_a),
        .len_i    (cfg.len),
        .rdata_i  (eng_rdata_a),
        .rd_idx_o (rd_idx_a),
        .beat_o   (beat_a)
    );

    sram_spu_reader u_rd_b (
        .clk300   (clk300),
        .rst_i    (rst_i),
        .start_i  (start),
        .offset_i (cfg.src_b),
        .len_i    (cfg.len),
        .rdata_i  (eng_rdata_b),
        .rd_idx_o (rd_idx_b),
        .beat_o   (beat_b)
    );

    sram_spu_combiner u_comb (
        .clk300   (clk300),
        .rst_i    (rst_i),
        .beat_a_i (beat_a),
        .beat_b_i (beat_b),
        .cfg_i    (cfg),
        .start_i  (start),
        .wr_o     (wr),
        .done_o   (done)
    );

endmodule

`default_nettype wire

// File: source/sram_spu_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sram_spu_wb_regs (
    input  var logic                                          clk300,
    input  var logic                                          rst_i,
    input  var logic [sram_spu_pkg::WB_ADR_WIDTH-1:0]         wb_adr_i,
    input  var logic [sram_spu_pkg::WB_DAT_WIDTH-1:0]         wb_dat_i,
    input  var logic [sram_spu_pkg::WB_SEL_WIDTH-1:0]         wb_sel_i,
    input  var logic                                          wb_we_i,
    input  var logic                                          wb_stb_i,
    input  var logic                                          done_i,
    input  var logic [2:0][sram_spu_pkg::WB_DAT_WIDTH-1:0]    bank_rdata_i,
    output var logic [sram_spu_pkg::WB_DAT_WIDTH-1:0]         wb_dat_o,
    output var logic                                          wb_ack_o,
    output var sram_spu_pkg::bank_wb_t [2:0]                  bank_req_o,
    output var sram_spu_pkg::spu_cfg_t                        cfg_o,
    output var logic                                          start_o
);
    import sram_spu_pkg::*;

    logic                    ack_q;
    logic                    acc;
    logic [1:0]              region;
    logic [BANK_AW-1:0]      idx;
    logic                    reg_wr;
    logic                    start_req;
    logic                    busy;
    logic                    done_q;
    spu_cfg_t                shadow_q;
    spu_cfg_t                cfg_q;
    run_state_e              state_q;
    logic [WB_DAT_WIDTH-1:0] reg_rdata;

    // access cycle is the one before ack
    assign acc       = wb_stb_i && !ack_q;
    assign region    = wb_adr_i[WB_ADR_WIDTH-1 -: 2];
    assign idx       = wb_adr_i[BANK_AW-1:0];
    assign reg_wr    = acc && wb_we_i && (region == REGION_REGS);
    assign busy      = (state_q != ST_IDLE);
    assign start_req = reg_wr && (idx == REG_CTRL) && wb_dat_i[0] && !busy;

    assign wb_ack_o = ack_q;
    assign cfg_o    = cfg_q;
    // start pulse lives in the single run cycle
    assign start_o  = (state_q == ST_RUN);

    always_comb begin
        for (int b = 0; b < 3; b++) begin
            bank_req_o[b].en  = 1'b0;
            bank_req_o[b].we  = wb_we_i;
            bank_req_o[b].idx = idx;
            bank_req_o[b].dat = wb_dat_i;
            bank_req_o[b].sel = wb_sel_i;
        end
        case (region)
            REGION_A: bank_req_o[0].en = acc;
            REGION_B: bank_req_o[1].en = acc;
            REGION_D: bank_req_o[2].en = acc;
            default: ;
        endcase
    end

    always_comb begin
        reg_rdata = '0;
        case (idx)
            REG_SRC_A:  reg_rdata[BANK_AW-1:0] = shadow_q.src_a;
            REG_SRC_B:  reg_rdata[BANK_AW-1:0] = shadow_q.src_b;
            REG_DST:    reg_rdata[BANK_AW-1:0] = shadow_q.dst;
            REG_LEN:    reg_rdata[LEN_W-1:0]   = shadow_q.len;
            REG_OP:     reg_rdata[2:0]         = shadow_q.op;
            REG_STATUS: reg_rdata[1:0]         = {done_q, busy};
            default: ;
        endcase
    end

    // banks answer with their registered read word
    always_comb begin
        case (region)
            REGION_A: wb_dat_o = bank_rdata_i[0];
            REGION_B: wb_dat_o = bank_rdata_i[1];
            REGION_D: wb_dat_o = bank_rdata_i[2];
            default:  wb_dat_o = reg_rdata;
        endcase
    end

    always_ff @(posedge clk300) begin
        if (rst_i) begin
            ack_q    <= 1'b0;
            shadow_q <= '0;
            cfg_q    <= '0;
            done_q   <= 1'b0;
            state_q  <= ST_IDLE;
        end else begin
            ack_q <= acc;
            if (reg_wr) begin
                case (idx)
                    REG_SRC_A: shadow_q.src_a <= wb_dat_i[BANK_AW-1:0];
                    REG_SRC_B: shadow_q.src_b <= wb_dat_i[BANK_AW-1:0];
                    REG_DST:   shadow_q.dst   <= wb_dat_i[BANK_AW-1:0];
                    REG_LEN:   shadow_q.len   <= wb_dat_i[LEN_W-1:0];
                    REG_OP:    shadow_q.op    <= spu_op_e'(wb_dat_i[2:0]);
                    default: ;
                endcase
            end
            // done is sticky until the next start
            if (start_req) begin
                cfg_q  <= shadow_q;
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;
            end
            case (state_q)
                ST_IDLE:  if (start_req) state_q <= ST_RUN;
                ST_RUN:   state_q <= ST_DRAIN;
                // wait for the combiner's final write
                ST_DRAIN: if (done_i) state_q <= ST_IDLE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    // the master holds its request until it sees ack
    stb_held_until_ack: assert property (@(posedge clk300) disable iff (rst_i)
        (wb_stb_i && !wb_ack_o) |=> (wb_stb_i && $stable(wb_adr_i) && $stable(wb_we_i)));

    // combiner finishes only once the run pulse has passed
    done_in_drain: assert property (@(posedge clk300) disable iff (rst_i)
        done_i |-> (state_q == ST_DRAIN));

endmodule

`default_nettype wire

// File: sram_spu.f
source/sram_spu_pkg.sv
source/sram_spu_wb_regs.sv
source/sram_spu_bank.sv
source/sram_spu_reader.sv
source/sram_spu_combiner.sv
source/sram_spu_top.sv
sim/tb_sram_spu.sv
